// ==== hw/eeprom_cmd_queue.sv ====
`timescale 1ns/1ps
`include "eeprom_params.svh"

module eeprom_cmd_queue
    import eeprom_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  cmd_valid,
    input  eeprom_op_e            cmd_op,
    input  logic [`EE_ADDR_W-1:0] cmd_addr,
    input  logic [`EE_DATA_W-1:0] cmd_wdata,
    input  logic                  q_pop,
    output logic                  q_valid,
    output eeprom_op_e            q_op,
    output logic [`EE_ADDR_W-1:0] q_addr,
    output logic [`EE_DATA_W-1:0] q_wdata,
    output logic                  credit_return
);

    localparam int PTR_W = (`EE_CMD_DEPTH > 1) ? $clog2(`EE_CMD_DEPTH) : 1;

    eeprom_op_e            op_mem   [`EE_CMD_DEPTH];
    logic [`EE_ADDR_W-1:0] addr_mem [`EE_CMD_DEPTH];
    logic [`EE_DATA_W-1:0] data_mem [`EE_CMD_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [PTR_W:0]        count;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(`EE_CMD_DEPTH - 1))
            return '0;
        return p + 1'b1;
    endfunction

    always_ff @(posedge CLK)
    begin
        if (cmd_valid)
        begin
            op_mem[wr_ptr]   <= cmd_op;
            addr_mem[wr_ptr] <= cmd_addr;
            data_mem[wr_ptr] <= cmd_wdata;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (cmd_valid)
                wr_ptr <= ptr_inc(wr_ptr);
            if (q_pop)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({cmd_valid, q_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign q_valid       = (count != '0);
    assign q_op          = op_mem[rd_ptr];
    assign q_addr        = addr_mem[rd_ptr];
    assign q_wdata       = data_mem[rd_ptr];
    assign credit_return = q_pop;   // one credit per finished command

    // host spent a credit it did not have
    a_no_overflow: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> (count != `EE_CMD_DEPTH));

    a_no_underflow: assert property (@(posedge CLK) disable iff (RESET)
        q_pop |-> (count != '0));

endmodule

// ==== hw/eeprom_ctrl_top.sv ====
`timescale 1ns/1ps
`include "eeprom_params.svh"

module eeprom_ctrl_top
    import eeprom_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  cmd_valid,
    input  eeprom_op_e            cmd_op,
    input  logic [`EE_ADDR_W-1:0] cmd_addr,
    input  logic [`EE_DATA_W-1:0] cmd_wdata,
    output logic                  credit_return,
    output logic                  rsp_valid,
    output logic [`EE_DATA_W-1:0] rsp_rdata,
    output logic                  rsp_err,
    output wire                   SCL,
    inout  wire                   SDA
);

    logic                  q_valid, q_pop;
    eeprom_op_e            q_op;
    logic [`EE_ADDR_W-1:0] q_addr;
    logic [`EE_DATA_W-1:0] q_wdata;
    logic                  scl_tick;
    logic                  cond_req, cond_done, cond_scl, cond_sda_low;
    cond_kind_e            cond_kind;
    logic                  shift_req, shift_done, shift_ack_out, ack_seen;
    eeprom_op_e            shift_dir;
    logic [7:0]            shift_byte, shift_rx;
    logic                  shift_scl, shift_sda_low;
    logic                  scl_out, sda_oe, sda_in;

    eeprom_cmd_queue u_queue (.*);

    eeprom_sequencer u_seq (.*);

    i2c_cond_gen u_cond (
        .CLK(CLK), .RESET(RESET), .scl_tick(scl_tick),
        .cond_req(cond_req), .cond_kind(cond_kind), .cond_done(cond_done),
        .scl_drive(cond_scl), .sda_drive_low(cond_sda_low)
    );

    i2c_byte_shifter u_shift (
        .CLK(CLK), .RESET(RESET), .scl_tick(scl_tick),
        .shift_req(shift_req), .shift_dir(shift_dir), .shift_byte(shift_byte),
        .shift_ack_out(shift_ack_out), .sda_in(sda_in), .shift_done(shift_done),
        .shift_rx(shift_rx), .ack_seen(ack_seen),
        .scl_drive(shift_scl), .sda_drive_low(shift_sda_low)
    );

    // open drain, pull-ups sit outside
    assign SCL    = scl_out ? 1'bz : 1'b0;
    assign SDA    = sda_oe ? 1'b0 : 1'bz;
    assign sda_in = SDA;

endmodule

// ==== hw/eeprom_params.svh ====
`ifndef EEPROM_PARAMS_SVH
`define EEPROM_PARAMS_SVH

// 2K x 8 part, so 11 address bits
`define EE_ADDR_W 11
`define EE_DATA_W 8

// fixed upper nibble of the control byte
`define EE_DEV_CODE 4'b1010

// queue entries, also the credits the host starts with
`define EE_CMD_DEPTH 4

// CLK cycles per SCL half period, 2 or more
`define EE_SCL_HALF 4

`endif

// ==== hw/eeprom_pkg.sv ====
package eeprom_pkg;

    typedef enum logic
    {
        op_write = 1'b0,
        op_read  = 1'b1
    } eeprom_op_e;

    // start and restart share one bus pattern
    typedef enum logic [1:0]
    {
        cond_start   = 2'd0,
        cond_restart = 2'd1,
        cond_stop    = 2'd2
    } cond_kind_e;

    typedef struct packed
    {
        logic [3:0] dev_code;
        logic [2:0] block;     // address bits 10..8
        logic       rw;        // 1 = read
    } ctrl_fields_t;

    // the byte as shifted on the wire, or split into its fields
    typedef union packed
    {
        logic [7:0]   raw;
        ctrl_fields_t f;
    } ctrl_byte_u;

endpackage

// ==== hw/eeprom_sequencer.sv ====
`timescale 1ns/1ps
`include "eeprom_params.svh"

module eeprom_sequencer
    import eeprom_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  q_valid,
    input  eeprom_op_e            q_op,
    input  logic [`EE_ADDR_W-1:0] q_addr,
    input  logic [`EE_DATA_W-1:0] q_wdata,
    input  logic                  cond_done,
    input  logic                  shift_done,
    input  logic [7:0]            shift_rx,
    input  logic                  ack_seen,
    input  logic                  cond_scl,
    input  logic                  cond_sda_low,
    input  logic                  shift_scl,
    input  logic                  shift_sda_low,
    output logic                  q_pop,
    output logic                  rsp_valid,
    output logic [`EE_DATA_W-1:0] rsp_rdata,
    output logic                  rsp_err,
    output logic                  scl_tick,
    output logic                  cond_req,
    output cond_kind_e            cond_kind,
    output logic                  shift_req,
    output eeprom_op_e            shift_dir,
    output logic [7:0]            shift_byte,
    output logic                  shift_ack_out,
    output logic                  scl_out,
    output logic                  sda_oe
);

    localparam int TW = $clog2(`EE_SCL_HALF);
    localparam int S_IDLE = 0, S_START = 1, S_CTRL_W = 2, S_ADDR = 3, S_DATA_W = 4;
    localparam int S_RESTART = 5, S_CTRL_R = 6, S_DATA_R = 7, S_STOP = 8, S_DONE = 9;
    localparam logic [9:0] ONE = 10'd1;

    logic [TW-1:0]         tick_cnt;
    logic [9:0]            state;
    logic [9:0]            state_nx;
    logic                  err;
    logic                  nack_now;
    logic                  rdata_ld;
    logic [`EE_DATA_W-1:0] rdata;
    logic                  cond_sel;
    logic                  shift_sel;
    ctrl_byte_u            ctrl_wr;
    ctrl_byte_u            ctrl_rd;

    always_ff @(posedge CLK)
    begin
        if (RESET || scl_tick)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    assign scl_tick = (tick_cnt == TW'(`EE_SCL_HALF - 1));

    always_comb
    begin
        ctrl_wr.f.dev_code = `EE_DEV_CODE;
        ctrl_wr.f.block    = q_addr[`EE_ADDR_W-1 -: 3];
        ctrl_wr.f.rw       = 1'b0;
        ctrl_rd            = ctrl_wr;
        ctrl_rd.f.rw       = 1'b1;
    end

    // every transition falls on a tick, so the next part starts in step
    always_comb
    begin
        state_nx      = state;
        cond_req      = 1'b0;
        cond_kind     = cond_stop;
        shift_req     = 1'b0;
        shift_dir     = op_write;
        shift_byte    = ctrl_wr.raw;
        shift_ack_out = 1'b1;
        nack_now      = 1'b0;
        rdata_ld      = 1'b0;
        unique case (1'b1)
            state[S_START]:
                if (cond_done)
                begin
                    state_nx  = ONE << S_CTRL_W;
                    shift_req = 1'b1;
                end
            state[S_CTRL_W], state[S_ADDR], state[S_DATA_W], state[S_CTRL_R]:
                if (shift_done)
                begin
                    if (!ack_seen || state[S_DATA_W])
                    begin
                        nack_now = !ack_seen;
                        state_nx = ONE << S_STOP;
                        cond_req = 1'b1;
                    end
                    else if (state[S_CTRL_W])
                    begin
                        state_nx   = ONE << S_ADDR;
                        shift_req  = 1'b1;
                        shift_byte = q_addr[7:0];
                    end
                    else if (state[S_CTRL_R])
                    begin
                        state_nx  = ONE << S_DATA_R;
                        shift_req = 1'b1;
                        shift_dir = op_read;   // single byte, ends with nack
                    end
                    else if (q_op == op_write)
                    begin
                        state_nx   = ONE << S_DATA_W;
                        shift_req  = 1'b1;
                        shift_byte = q_wdata;
                    end
                    else
                    begin
                        state_nx  = ONE << S_RESTART;
                        cond_req  = 1'b1;
                        cond_kind = cond_restart;
                    end
                end
            state[S_RESTART]:
                if (cond_done)
                begin
                    state_nx   = ONE << S_CTRL_R;
                    shift_req  = 1'b1;
                    shift_byte = ctrl_rd.raw;
                end
            state[S_DATA_R]:
                if (shift_done)
                begin
                    rdata_ld = 1'b1;
                    state_nx = ONE << S_STOP;
                    cond_req = 1'b1;
                end
            state[S_STOP]:
                if (cond_done)
                    state_nx = ONE << S_DONE;
            state[S_DONE]:
                state_nx = ONE << S_IDLE;
            default:
                if (scl_tick && q_valid)
                begin
                    state_nx  = ONE << S_START;
                    cond_req  = 1'b1;
                    cond_kind = cond_start;
                end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= ONE << S_IDLE;
            err    <= 1'b0;
            rdata  <= '0;
            sda_oe <= 1'b0;
        end
        else
        begin
            state <= state_nx;
            if (state[S_IDLE])
            begin
                err   <= 1'b0;
                rdata <= '0;
            end
            else
            begin
                err <= err | nack_now;
                if (rdata_ld)
                    rdata <= shift_rx;
            end
            sda_oe <= (cond_sel && cond_sda_low) || (shift_sel && shift_sda_low); // lags SCL
        end
    end

    assign cond_sel  = state[S_START] || state[S_RESTART] || state[S_STOP];
    assign shift_sel = state[S_CTRL_W] || state[S_ADDR] || state[S_DATA_W] ||
                       state[S_CTRL_R] || state[S_DATA_R];
    assign scl_out   = cond_sel ? cond_scl : (shift_sel ? shift_scl : 1'b1);

    assign q_pop     = state[S_DONE];
    assign rsp_valid = state[S_DONE] && (q_op == op_read);
    assign rsp_err   = err;
    assign rsp_rdata = rdata;

    // data bits only move while SCL is low
    a_sda_stable_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        shift_sel && scl_out |-> $stable(sda_oe));

endmodule

// ==== hw/i2c_byte_shifter.sv ====
`timescale 1ns/1ps
`include "eeprom_params.svh"

module i2c_byte_shifter
    import eeprom_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       scl_tick,
    input  logic       shift_req,
    input  eeprom_op_e shift_dir,
    input  logic [7:0] shift_byte,
    input  logic       shift_ack_out,
    input  logic       sda_in,
    output logic       shift_done,
    output logic [7:0] shift_rx,
    output logic       ack_seen,
    output logic       scl_drive,
    output logic       sda_drive_low
);

    logic       active;
    logic       half;       // 0 = SCL low half, 1 = SCL high half
    logic [3:0] bit_cnt;
    logic [7:0] sh;
    eeprom_op_e dir_q;
    logic       ack_out_q;
    logic       last_bit;
    logic       sample;

    assign last_bit = (bit_cnt == 4'd8);
    assign sample   = active && scl_tick && half;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active  <= 1'b0;
            half    <= 1'b0;
            bit_cnt <= '0;
        end
        else if (shift_req)
        begin
            active  <= 1'b1;
            half    <= 1'b0;
            bit_cnt <= '0;
        end
        else if (active && scl_tick)
        begin
            if (!half)
                half <= 1'b1;
            else if (last_bit)
            begin
                active <= 1'b0;
                half   <= 1'b0;
            end
            else
            begin
                bit_cnt <= bit_cnt + 1'b1;
                half    <= 1'b0;
            end
        end
    end

    // one register shifts out and in, msb first
    always_ff @(posedge CLK)
    begin
        if (shift_req)
        begin
            sh        <= shift_byte;
            dir_q     <= shift_dir;
            ack_out_q <= shift_ack_out;
        end
        else if (sample && !last_bit)
            sh <= {sh[6:0], sda_in};
    end

    assign shift_done = sample && last_bit;
    assign shift_rx   = sh;
    assign ack_seen   = ~sda_in;    // valid with shift_done
    assign scl_drive  = active ? half : 1'b1;

    always_comb
    begin
        if (!active)
            sda_drive_low = 1'b0;
        else if (!last_bit)
            sda_drive_low = (dir_q == op_write) ? ~sh[7] : 1'b0;
        else
            sda_drive_low = (dir_q == op_read) ? ~ack_out_q : 1'b0; // slave acks a write
    end

    // requests come from the sequencer only on its tick
    a_req_on_tick: assert property (@(posedge CLK) disable iff (RESET)
        shift_req |-> scl_tick && (!active || shift_done));

endmodule

// ==== hw/i2c_cond_gen.sv ====
`timescale 1ns/1ps
`include "eeprom_params.svh"

module i2c_cond_gen
    import eeprom_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       scl_tick,
    input  logic       cond_req,
    input  cond_kind_e cond_kind,
    output logic       cond_done,
    output logic       scl_drive,
    output logic       sda_drive_low
);

    typedef enum logic [1:0] {cg_idle, cg_h0, cg_h1} cg_state_e;

    cg_state_e state;
    logic      is_stop;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= cg_idle;
            is_stop <= 1'b0;
        end
        else
        begin
            case (state)
                cg_idle:
                begin
                    if (cond_req)
                    begin
                        state   <= cg_h0;
                        is_stop <= (cond_kind == cond_stop);
                    end
                end
                cg_h0:
                    if (scl_tick)
                        state <= cg_h1;
                default:
                    if (scl_tick)
                        state <= cg_idle;
            endcase
        end
    end

    assign cond_done = (state == cg_h1) && scl_tick;

    // SDA moves one CLK after SCL in the sequencer, so the h1 edge lands with SCL high
    always_comb
    begin
        case (state)
            cg_h0:
            begin
                scl_drive     = 1'b0;
                sda_drive_low = is_stop;    // stop pulls low first
            end
            cg_h1:
            begin
                scl_drive     = 1'b1;
                sda_drive_low = ~is_stop;   // start falls, stop rises
            end
            default:
            begin
                scl_drive     = 1'b1;
                sda_drive_low = 1'b0;
            end
        endcase
    end

    a_req_when_idle: assert property (@(posedge CLK) disable iff (RESET)
        cond_req |-> (state == cg_idle) && scl_tick);

endmodule

// ==== list.f ====
+incdir+hw
hw/eeprom_pkg.sv
hw/eeprom_cmd_queue.sv
hw/i2c_cond_gen.sv
hw/i2c_byte_shifter.sv
hw/eeprom_sequencer.sv
hw/eeprom_ctrl_top.sv
verification/eeprom_model.sv
verification/eeprom_checker.sv
verification/eeprom_tb.sv

// ==== verification/eeprom_checker.sv ====
`timescale 1ns/1ps
`include "eeprom_params.svh"

module eeprom_checker
    import eeprom_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  cmd_valid,
    input  eeprom_op_e            cmd_op,
    input  logic [`EE_ADDR_W-1:0] cmd_addr,
    input  logic [`EE_DATA_W-1:0] cmd_wdata,
    input  logic                  nack_next,
    input  logic                  credit_return,
    input  logic                  rsp_valid,
    input  logic [`EE_DATA_W-1:0] rsp_rdata,
    input  logic                  rsp_err,
    input  wire                   SCL,
    input  wire                   SDA,
    output int                    err_count
);

    typedef struct packed
    {
        eeprom_op_e            op;
        logic [`EE_ADDR_W-1:0] addr;
        logic [`EE_DATA_W-1:0] wdata;
        logic                  nack;   // slave told to refuse
    } cmd_rec_t;

    cmd_rec_t              pending [$];
    cmd_rec_t              rec;
    logic [`EE_DATA_W-1:0] ref_mem [int];
    logic [`EE_DATA_W-1:0] exp_rdata;

    // last good write, erased parts read FF
    function automatic logic [`EE_DATA_W-1:0] ref_read(input logic [`EE_ADDR_W-1:0] a);
        if (ref_mem.exists(a))
            return ref_mem[a];
        return 8'hFF;
    endfunction

    task automatic compare_field(input string name, input logic [7:0] got,
                                 input logic [7:0] exp);
        if (got !== exp)
        begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    initial
        err_count = 0;

    always @(posedge CLK)
    begin
        if (!RESET)
        begin
            if (credit_return)
            begin
                if (pending.size() == 0)
                begin
                    $display("credit returned with no command outstanding");
                    err_count++;
                end
                else
                begin
                    rec = pending.pop_front();
                    compare_field("rsp_err", rsp_err, rec.nack);
                    if (SCL !== 1'b1 || SDA !== 1'b1)
                    begin
                        $display("bus not released at end of command");
                        err_count++;
                    end
                    if (rec.op == op_read)
                    begin
                        exp_rdata = rec.nack ? '0 : ref_read(rec.addr);
                        compare_field("rsp_valid", rsp_valid, 1'b1);
                        compare_field("rsp_rdata", rsp_rdata, exp_rdata);
                    end
                    else
                    begin
                        compare_field("rsp_valid", rsp_valid, 1'b0);
                        if (!rsp_err)
                            ref_mem[rec.addr] = rec.wdata;
                    end
                end
            end
            else if (rsp_valid)
            begin
                $display("read response came without a credit return");
                err_count++;
            end
            if (cmd_valid)
                pending.push_back('{op: cmd_op, addr: cmd_addr, wdata: cmd_wdata,
                                    nack: nack_next});
        end
    end

endmodule

// ==== verification/eeprom_model.sv ====
`timescale 1ns/1ps
`include "eeprom_params.svh"

module eeprom_model
    import eeprom_pkg::*;
(
    input  wire  SCL,
    inout  wire  SDA,
    input  logic nack_next   // refuse control bytes while high
);

    typedef enum {m_idle, m_rx, m_ack, m_tx, m_mack} phase_e;

    logic [7:0]            mem [0:(1 << `EE_ADDR_W) - 1];
    phase_e                phase = m_idle;
    logic                  sda_low = 1'b0;
    int                    bit_cnt;
    int                    byte_idx;
    logic [7:0]            shreg;
    logic [`EE_ADDR_W-1:0] addr;
    logic                  read_next;
    ctrl_byte_u            ctrl;

    assign SDA = sda_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < (1 << `EE_ADDR_W); i++)
            mem[i] = 8'hFF;
    end

    // byte 0 is control, 1 is low address, 2 is write data
    task take_byte();
        ctrl.raw = shreg;
        if (byte_idx == 0 && (ctrl.f.dev_code != `EE_DEV_CODE || nack_next))
            phase = m_idle;    // no ack, master sees SDA high
        else
        begin
            if (byte_idx == 0)
            begin
                addr[`EE_ADDR_W-1 -: 3] = ctrl.f.block;
                read_next               = ctrl.f.rw;
            end
            else if (byte_idx == 1)
                addr[7:0] = shreg;
            else if (byte_idx == 2)
                mem[addr] = shreg;
            byte_idx++;
            sda_low = 1'b1;
            phase   = m_ack;
        end
    endtask

    // start or repeated start
    always @(negedge SDA)
    begin
        if (SCL === 1'b1)
        begin
            phase     = m_rx;
            bit_cnt   = 0;
            byte_idx  = 0;
            read_next = 1'b0;
            sda_low   = 1'b0;
        end
    end

    always @(posedge SDA)
    begin
        if (SCL === 1'b1)
            phase = m_idle;   // stop
    end

    always @(posedge SCL)
    begin
        if (phase == m_rx)
        begin
            shreg = {shreg[6:0], SDA};
            bit_cnt++;
        end
        else if (phase == m_tx)
            bit_cnt++;
    end

    always @(negedge SCL)
    begin
        case (phase)
            m_rx:
                if (bit_cnt == 8)
                    take_byte();
            m_ack:
            begin
                sda_low = 1'b0;
                bit_cnt = 0;
                if (read_next)
                begin
                    phase   = m_tx;
                    shreg   = mem[addr];
                    sda_low = ~shreg[7];
                end
                else
                    phase = m_rx;
            end
            m_tx:
                if (bit_cnt == 8)
                begin
                    sda_low = 1'b0;   // master answers nack
                    phase   = m_mack;
                end
                else
                begin
                    shreg   = shreg << 1;
                    sda_low = ~shreg[7];
                end
            m_mack:
                phase = m_idle;
            default:
                ;
        endcase
    end

endmodule

// ==== verification/eeprom_tb.sv ====
`timescale 1ns/1ps
`include "eeprom_params.svh"

module eeprom_tb
    import eeprom_pkg::*;
();

    localparam int NUM_CMDS    = 32;
    localparam int READ_CYCLES = (2 + 36 + 2 + 36 + 2 + 2) * `EE_SCL_HALF + 4;
    localparam int LIMIT       = NUM_CMDS * READ_CYCLES * 2;

    logic                  CLK;
    logic                  RESET;
    logic                  cmd_valid;
    eeprom_op_e            cmd_op;
    logic [`EE_ADDR_W-1:0] cmd_addr;
    logic [`EE_DATA_W-1:0] cmd_wdata;
    logic                  credit_return;
    logic                  rsp_valid;
    logic [`EE_DATA_W-1:0] rsp_rdata;
    logic                  rsp_err;
    logic                  nack_next;
    wire                   scl_w;
    wire                   sda_w;
    int                    credits;
    int                    tb_errors;
    int                    chk_errors;
    int                    err_mark;
    int                    passed;
    int                    failed;
    int                    cycle_cnt = 0;
    integer                seed;

    pullup (scl_w);
    pullup (sda_w);

    eeprom_ctrl_top dut (
        .CLK(CLK), .RESET(RESET), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
        .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata), .credit_return(credit_return),
        .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata), .rsp_err(rsp_err),
        .SCL(scl_w), .SDA(sda_w)
    );

    eeprom_model u_model (.SCL(scl_w), .SDA(sda_w), .nack_next(nack_next));

    eeprom_checker u_checker (
        .CLK(CLK), .RESET(RESET), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
        .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata), .nack_next(nack_next),
        .credit_return(credit_return), .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata),
        .rsp_err(rsp_err), .SCL(scl_w), .SDA(sda_w), .err_count(chk_errors)
    );

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    always @(posedge CLK)
        cycle_cnt <= cycle_cnt + 1;

    // host credit count, spent on push and returned on credit_return
    always @(posedge CLK)
    begin
        if (RESET)
            credits = `EE_CMD_DEPTH;
        else
        begin
            credits = credits - int'(cmd_valid) + int'(credit_return);
            if (credits < 0 || credits > `EE_CMD_DEPTH)
            begin
                $display("credit count out of range: %0d", credits);
                tb_errors++;
            end
        end
    end

    // called 2 ns after a rising edge
    task automatic issue_cmd(input eeprom_op_e op, input logic [`EE_ADDR_W-1:0] addr,
                             input logic [`EE_DATA_W-1:0] data);
        while (credits == 0)
        begin
            @(posedge CLK);
            #2;
        end
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_addr  = addr;
        cmd_wdata = data;
        @(posedge CLK);
        #2;
        cmd_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (credits != `EE_CMD_DEPTH)
        begin
            @(posedge CLK);
            #2;
        end
        repeat (2) @(posedge CLK);
        #2;
        if (scl_w !== 1'b1 || sda_w !== 1'b1)
        begin
            $display("bus not released while idle: SCL=%b SDA=%b", scl_w, sda_w);
            tb_errors++;
        end
    endtask

    task automatic write_then_read(input logic [`EE_ADDR_W-1:0] addr,
                                   input logic [`EE_DATA_W-1:0] data);
        issue_cmd(op_write, addr, data);
        issue_cmd(op_read, addr, 8'h00);
        wait_drained();
    endtask

    task automatic close_test(input string name);
        int now;
        now = tb_errors + chk_errors;
        if (now == err_mark)
        begin
            $display("test %s: pass", name);
            passed++;
        end
        else
        begin
            $display("test %s: fail with %0d errors", name, now - err_mark);
            failed++;
        end
        err_mark = now;
    endtask

    initial
    begin
        logic [31:0] r;
        seed      = 98;
        RESET     = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = op_write;
        cmd_addr  = '0;
        cmd_wdata = '0;
        nack_next = 1'b0;
        tb_errors = 0;
        err_mark  = 0;
        passed    = 0;
        failed    = 0;
        repeat (16) @(posedge CLK);
        #2;
        RESET = 1'b0;
        wait_drained();
        close_test("reset idle");

        // high bits differ so the block field changes
        write_then_read(11'h1A5, 8'h3C);
        write_then_read(11'h4A5, 8'hC3);
        write_then_read(11'h7FF, 8'h81);
        issue_cmd(op_read, 11'h1A5, 8'h00);   // same low byte, other block
        wait_drained();
        close_test("write then read");

        issue_cmd(op_read, 11'h6C3, 8'h00);
        wait_drained();
        close_test("unwritten reads ff");

        for (int i = 0; i < 20; i++)
        begin
            r = $random(seed);
            issue_cmd(r[12] ? op_read : op_write, {r[10:8], 6'h15, r[1:0]}, r[23:16]);
        end
        wait_drained();
        close_test("random back to back");

        issue_cmd(op_write, 11'h25A, 8'h5A);
        wait_drained();
        nack_next = 1'b1;
        issue_cmd(op_write, 11'h25A, 8'h33);
        wait_drained();
        nack_next = 1'b0;
        issue_cmd(op_read, 11'h25A, 8'h00);
        wait_drained();
        nack_next = 1'b1;
        issue_cmd(op_read, 11'h25A, 8'h00);
        wait_drained();
        nack_next = 1'b0;
        close_test("not acknowledge");

        $display("tests passed %0d failed %0d", passed, failed);
        if (failed == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    initial
    begin
        wait (cycle_cnt >= LIMIT);
        $display("timeout: run did not finish within %0d cycles", LIMIT);
        $display("** FAIL **");
        $finish;
    end

endmodule
